// ==== cfg_table.sv ====
`timescale 1ns/100ps
`include "eth_cfg_macros.svh"
`default_nettype none

module cfg_table (
   input  logic                            cfg_clk,
   input  logic                            rst_n,
   input  logic                            wr_stb,
   input  eth_cfg_pkg::cfg_wr_t            wr,
   output logic [47:0]                     station_mac,
   output logic [31:0]                     station_ip,
   output logic [`ETH_UDP_SLOTS-1:0][15:0] udp_ports
);

   localparam int SLOTS = `ETH_UDP_SLOTS;
   localparam int MAC_B = `ETH_MAC_BYTES;
   localparam int IP_B  = `ETH_IP_BYTES;
   localparam int IDX_W = `ETH_IDX_W;

   logic [MAC_B-1:0]       mac_be;
   logic [IP_B-1:0]        ip_be;
   logic                   port_hi_we;
   logic                   port_lo_we;
   logic [47:0]            mac_q;
   logic [31:0]            ip_q;
   logic [SLOTS-1:0][15:0] ports_q;

   // ------------------------------------------------------------------------
   // Byte enables
   // ------------------------------------------------------------------------
   // Index 0 is the MAC MSB, index MAC_B the IP MSB
   always_comb begin
      mac_be = '0;
      ip_be  = '0;
      if (wr_stb && (wr.space == eth_cfg_pkg::SPACE_MACIP)) begin
         for (int b = 0; b < MAC_B; b++) begin
            mac_be[b] = (wr.idx == IDX_W'(b));
         end
         for (int b = 0; b < IP_B; b++) begin
            ip_be[b] = (wr.idx == IDX_W'(MAC_B + b));
         end
      end
   end

   // One half of one slot per UDP write
   assign port_hi_we = wr_stb && (wr.space == eth_cfg_pkg::SPACE_UDP) && !wr.half;
   assign port_lo_we = wr_stb && (wr.space == eth_cfg_pkg::SPACE_UDP) && wr.half;

   // ------------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------------
   // Defaults from the macro header, all ports closed
   always_ff @(posedge cfg_clk or negedge rst_n) begin
      if (!rst_n) begin
         mac_q   <= `ETH_DEFAULT_MAC;
         ip_q    <= `ETH_DEFAULT_IP;
         ports_q <= '0;
      end else begin
         // Enabled byte lane gets the write data, others hold
         for (int b = 0; b < MAC_B; b++) begin
            if (mac_be[b]) begin
               mac_q[8*(MAC_B-1-b) +: 8] <= wr.data;
            end
         end
         for (int b = 0; b < IP_B; b++) begin
            if (ip_be[b]) begin
               ip_q[8*(IP_B-1-b) +: 8] <= wr.data;
            end
         end
         // Port halves
         if (port_hi_we) begin
            ports_q[wr.slot][15:8] <= wr.data;
         end
         if (port_lo_we) begin
            ports_q[wr.slot][7:0] <= wr.data;
         end
      end
   end

   // Straight out to the matcher
   assign station_mac = mac_q;
   assign station_ip  = ip_q;
   assign udp_ports   = ports_q;

endmodule

`default_nettype wire

// ==== cfg_write_decode.sv ====
`timescale 1ns/100ps
`include "eth_cfg_macros.svh"
`default_nettype none

module cfg_write_decode (
   input  logic                   cfg_clk,
   input  logic                   rst_n,
   input  logic                   cfg_valid,
   input  eth_cfg_pkg::cfg_addr_u cfg_addr,
   input  logic [7:0]             cfg_wdata,
   output logic                   wr_stb,
   output eth_cfg_pkg::cfg_wr_t   wr,
   output logic                   cfg_err
);

   // Bytes backed by the table in MAC/IP space
   localparam int MACIP_BYTES = `ETH_MAC_BYTES + `ETH_IP_BYTES;

   logic                 is_udp;
   logic                 idx_legal;
   eth_cfg_pkg::cfg_wr_t wr_next;

   // ------------------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------------------
   // Select bit sits in the same place in both views
   assign is_udp = (cfg_addr.macip.sel == eth_cfg_pkg::SPACE_UDP);

   // Every UDP address is legal
   // MAC/IP indices 10..15 have no backing byte
   assign idx_legal = is_udp || (int'(cfg_addr.macip.idx) < MACIP_BYTES);

   always_comb begin
      wr_next       = '0;
      wr_next.space = cfg_addr.macip.sel;
      wr_next.data  = cfg_wdata;
      if (is_udp) begin
         // Slot number and half from the UDP view
         wr_next.slot = cfg_addr.udp.slot[`ETH_SLOT_W-1:0];
         wr_next.half = cfg_addr.udp.half;
      end else begin
         // Byte index from the MAC/IP view
         wr_next.idx  = cfg_addr.macip.idx;
      end
   end

   // ------------------------------------------------------------------------
   // Strobe registers
   // ------------------------------------------------------------------------
   // Exactly one of wr_stb or cfg_err per host strobe
   always_ff @(posedge cfg_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_stb  <= 1'b0;
         cfg_err <= 1'b0;
      end else begin
         wr_stb  <= cfg_valid & idx_legal;
         cfg_err <= cfg_valid & ~idx_legal;
      end
   end

   // Write payload, held between strobes
   always_ff @(posedge cfg_clk) begin
      if (cfg_valid) begin
         wr <= wr_next;
      end
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
eth_cfg_pkg.sv
cfg_write_decode.sv
cfg_table.sv
rx_dest_match.sv
eth_cfg_top.sv
eth_cfg_assert.sv
tb_eth_cfg.sv

// ==== eth_cfg_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module eth_cfg_assert (
   input logic cfg_clk,
   input logic rst_n,
   input logic cfg_valid,
   input logic wr_stb,
   input logic cfg_err,
   input logic cfg_enable_rx,
   input logic hdr_stb,
   input logic match_stb
);

   // Failed assertions so far
   int fail_cnt = 0;

   // ------------------------------------------------------------------------
   // Host write strobes
   // ------------------------------------------------------------------------
   // Error pulse only one cycle after a host strobe
   property err_after_valid;
      @(posedge cfg_clk) disable iff (!rst_n)
         cfg_err |-> $past(cfg_valid);
   endproperty
   a_err_after_valid: assert property (err_after_valid)
      else begin
         fail_cnt++;
         $error("cfg_err high without cfg_valid one cycle earlier");
      end

   // Each host strobe answered next cycle, by a write or an error
   a_valid_answered: assert property (
      @(posedge cfg_clk) disable iff (!rst_n)
         $past(cfg_valid) |-> (wr_stb || cfg_err))
      else begin
         fail_cnt++;
         $error("cfg_valid gave neither wr_stb nor cfg_err");
      end

   // Legal and illegal never both
   a_wr_err_excl: assert property (
      @(posedge cfg_clk) disable iff (!rst_n)
         !(wr_stb && cfg_err))
      else begin
         fail_cnt++;
         $error("wr_stb and cfg_err high together");
      end

   // ------------------------------------------------------------------------
   // Header pipeline
   // ------------------------------------------------------------------------
   // Two stages, gated at the input
   a_match_latency: assert property (
      @(posedge cfg_clk) disable iff (!rst_n)
         match_stb == $past(hdr_stb & cfg_enable_rx, 2))
      else begin
         fail_cnt++;
         $error("match_stb not two cycles after an accepted hdr_stb");
      end

endmodule

`default_nettype wire

// ==== eth_cfg_macros.svh ====
`ifndef ETH_CFG_MACROS_SVH
`define ETH_CFG_MACROS_SVH
`default_nettype none

// ---------------------------------------------------------------------------
// Station defaults loaded by reset
// ---------------------------------------------------------------------------
// Locally administered unicast MAC
`define ETH_DEFAULT_MAC 48'h02_00_5e_10_00_01
// 192.168.7.4
`define ETH_DEFAULT_IP {8'd192, 8'd168, 8'd7, 8'd4}

// ---------------------------------------------------------------------------
// Table geometry
// ---------------------------------------------------------------------------
// UDP listening slots, 4 also valid with a slot width of 2
`define ETH_UDP_SLOTS 8
`define ETH_SLOT_W 3

// MAC/IP byte space, MAC bytes first then IP bytes
`define ETH_MAC_BYTES 6
`define ETH_IP_BYTES 4
`define ETH_IDX_W 4

`default_nettype wire
`endif

// ==== eth_cfg_pkg.sv ====
`include "eth_cfg_macros.svh"
`default_nettype none

package eth_cfg_pkg;

   // Space select values, cfg_addr bit 4
   localparam logic SPACE_MACIP = 1'b0;
   localparam logic SPACE_UDP   = 1'b1;

   // ------------------------------------------------------------------------
   // Host address, two views of the same 5 bits
   // ------------------------------------------------------------------------
   // MAC/IP view: byte 0..5 MAC, 6..9 IP, both MSB first
   typedef struct packed {
      logic                  sel;
      logic [`ETH_IDX_W-1:0] idx;
   } macip_view_t;

   // UDP view: slot number plus half select
   // Half 0 is the port high byte
   typedef struct packed {
      logic       sel;
      logic [2:0] slot;
      logic       half;
   } udp_view_t;

   typedef union packed {
      macip_view_t macip;
      udp_view_t   udp;
   } cfg_addr_u;

   // ------------------------------------------------------------------------
   // Table write, one byte per strobe
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic                   space;
      logic [`ETH_IDX_W-1:0]  idx;
      logic [`ETH_SLOT_W-1:0] slot;
      logic                   half;
      logic [7:0]             data;
   } cfg_wr_t;

   // Parsed receive header, destination fields only
   typedef struct packed {
      logic [47:0] dst_mac;
      logic [31:0] dst_ip;
      logic [15:0] dst_port;
   } rx_hdr_t;

   // Match verdict
   typedef struct packed {
      logic                   mac_ok;
      logic                   ip_ok;
      logic                   hit;
      logic [`ETH_SLOT_W-1:0] slot;
   } match_t;

endpackage

`default_nettype wire

// ==== eth_cfg_top.sv ====
`timescale 1ns/100ps
`include "eth_cfg_macros.svh"
`default_nettype none

module eth_cfg_top (
   input  logic                   cfg_clk,
   input  logic                   rst_n,
   input  logic                   cfg_valid,
   input  eth_cfg_pkg::cfg_addr_u cfg_addr,
   input  logic [7:0]             cfg_wdata,
   input  logic                   cfg_enable_rx,
   input  logic                   hdr_stb,
   input  eth_cfg_pkg::rx_hdr_t   hdr,
   output logic                   cfg_err,
   output logic                   match_stb,
   output eth_cfg_pkg::match_t    match
);

   // Decoder to table
   logic                            wr_stb;
   eth_cfg_pkg::cfg_wr_t            wr;

   // Table to matcher
   logic [47:0]                     station_mac;
   logic [31:0]                     station_ip;
   logic [`ETH_UDP_SLOTS-1:0][15:0] udp_ports;

   // ------------------------------------------------------------------------
   // Host write path
   // ------------------------------------------------------------------------
   cfg_write_decode cfg_write_decode_inst (
      .cfg_clk   (cfg_clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .wr_stb    (wr_stb),
      .wr        (wr),
      .cfg_err   (cfg_err)
   );

   // Station addresses and port slots
   cfg_table cfg_table_inst (
      .cfg_clk     (cfg_clk),
      .rst_n       (rst_n),
      .wr_stb      (wr_stb),
      .wr          (wr),
      .station_mac (station_mac),
      .station_ip  (station_ip),
      .udp_ports   (udp_ports)
   );

   // ------------------------------------------------------------------------
   // Receive destination check
   // ------------------------------------------------------------------------
   rx_dest_match rx_dest_match_inst (
      .cfg_clk       (cfg_clk),
      .rst_n         (rst_n),
      .cfg_enable_rx (cfg_enable_rx),
      .hdr_stb       (hdr_stb),
      .hdr           (hdr),
      .station_mac   (station_mac),
      .station_ip    (station_ip),
      .udp_ports     (udp_ports),
      .match_stb     (match_stb),
      .match         (match)
   );

endmodule

`default_nettype wire

// ==== rx_dest_match.sv ====
`timescale 1ns/100ps
`include "eth_cfg_macros.svh"
`default_nettype none

module rx_dest_match (
   input  logic                            cfg_clk,
   input  logic                            rst_n,
   input  logic                            cfg_enable_rx,
   input  logic                            hdr_stb,
   input  eth_cfg_pkg::rx_hdr_t            hdr,
   input  logic [47:0]                     station_mac,
   input  logic [31:0]                     station_ip,
   input  logic [`ETH_UDP_SLOTS-1:0][15:0] udp_ports,
   output logic                            match_stb,
   output eth_cfg_pkg::match_t             match
);

   localparam int SLOTS  = `ETH_UDP_SLOTS;
   localparam int SLOT_W = `ETH_SLOT_W;

   logic                mac_ok_c;
   logic                ip_ok_c;
   logic                hdr_take;
   logic                s1_vld;
   logic                s1_mac_ok;
   logic                s1_ip_ok;
   logic [15:0]         s1_port;
   logic [SLOTS-1:0]    slot_hit;
   logic                any_hit;
   logic [SLOT_W-1:0]   low_slot;
   eth_cfg_pkg::match_t match_next;

   // ------------------------------------------------------------------------
   // Stage one, address checks
   // ------------------------------------------------------------------------
   // Own MAC or broadcast
   assign mac_ok_c = (hdr.dst_mac == station_mac) || (hdr.dst_mac == '1);
   assign ip_ok_c  = (hdr.dst_ip == station_ip);

   // Headers seen while receive is off are dropped here
   assign hdr_take = hdr_stb & cfg_enable_rx;

   always_ff @(posedge cfg_clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_vld <= 1'b0;
      end else begin
         s1_vld <= hdr_take;
      end
   end

   // Port travels on for the slot compare
   always_ff @(posedge cfg_clk) begin
      if (hdr_take) begin
         s1_mac_ok <= mac_ok_c;
         s1_ip_ok  <= ip_ok_c;
         s1_port   <= hdr.dst_port;
      end
   end

   // ------------------------------------------------------------------------
   // Stage two, port lookup
   // ------------------------------------------------------------------------
   // Zero marks a closed slot, never a match
   always_comb begin
      for (int i = 0; i < SLOTS; i++) begin
         slot_hit[i] = (udp_ports[i] != 16'h0000) && (udp_ports[i] == s1_port);
      end
   end

   // Lowest slot wins, scan from the top down
   always_comb begin
      any_hit  = 1'b0;
      low_slot = '0;
      for (int i = SLOTS - 1; i >= 0; i--) begin
         if (slot_hit[i]) begin
            any_hit  = 1'b1;
            low_slot = SLOT_W'(i);
         end
      end
   end

   always_comb begin
      match_next        = '0;
      match_next.mac_ok = s1_mac_ok;
      match_next.ip_ok  = s1_ip_ok;
      match_next.hit    = s1_mac_ok & s1_ip_ok & any_hit;
      // Slot reads zero unless hit
      if (match_next.hit) begin
         match_next.slot = low_slot;
      end
   end

   always_ff @(posedge cfg_clk or negedge rst_n) begin
      if (!rst_n) begin
         match_stb <= 1'b0;
      end else begin
         match_stb <= s1_vld;
      end
   end

   // Verdict held until the next header
   always_ff @(posedge cfg_clk) begin
      if (s1_vld) begin
         match <= match_next;
      end
   end

endmodule

`default_nettype wire

// ==== tb_eth_cfg.sv ====
`timescale 1ns/100ps
`include "eth_cfg_macros.svh"
`default_nettype none

module tb_eth_cfg;

   localparam int CLK_NS = 40;
   // Cycle budget of each test
   localparam int RESET_CYC   = 12;
   localparam int DEFAULT_CYC = 40;
   localparam int STATION_CYC = 80;
   localparam int PORTS_CYC   = 100;
   localparam int ILLEGAL_CYC = 60;
   localparam int STREAM_CYC  = 60;
   localparam int TOTAL_CYC   = RESET_CYC + DEFAULT_CYC + STATION_CYC + PORTS_CYC
                                + ILLEGAL_CYC + STREAM_CYC;

   logic                   cfg_clk;
   logic                   rst_n;
   logic                   cfg_valid;
   eth_cfg_pkg::cfg_addr_u cfg_addr;
   logic [7:0]             cfg_wdata;
   logic                   cfg_enable_rx;
   logic                   hdr_stb;
   eth_cfg_pkg::rx_hdr_t   hdr;
   logic                   cfg_err;
   logic                   match_stb;
   eth_cfg_pkg::match_t    match;

   // Table model, follows the writes issued here
   logic [47:0] model_mac;
   logic [31:0] model_ip;
   logic [15:0] model_ports [`ETH_UDP_SLOTS];

   // Verdicts in flight, due cycle and expected value
   int                  due_q[$];
   eth_cfg_pkg::match_t exp_q[$];

   int          cyc = 0;
   integer      seed = 32'h6f90;
   logic [15:0] port_a;
   logic [15:0] port_b;
   logic [15:0] port_c;

   eth_cfg_top eth_cfg_top_inst (
      .cfg_clk       (cfg_clk),
      .rst_n         (rst_n),
      .cfg_valid     (cfg_valid),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .cfg_enable_rx (cfg_enable_rx),
      .hdr_stb       (hdr_stb),
      .hdr           (hdr),
      .cfg_err       (cfg_err),
      .match_stb     (match_stb),
      .match         (match)
   );

   bind eth_cfg_top eth_cfg_assert eth_cfg_assert_inst (
      .cfg_clk       (cfg_clk),
      .rst_n         (rst_n),
      .cfg_valid     (cfg_valid),
      .wr_stb        (wr_stb),
      .cfg_err       (cfg_err),
      .cfg_enable_rx (cfg_enable_rx),
      .hdr_stb       (hdr_stb),
      .match_stb     (match_stb)
   );

   initial begin
      cfg_clk = 1'b0;
      forever #(CLK_NS / 2) cfg_clk = ~cfg_clk;
   end

   // Cycle count, read on falling edges
   always @(posedge cfg_clk) begin
      cyc <= cyc + 1;
   end

   // ------------------------------------------------------------------------
   // Error handling and compares
   // ------------------------------------------------------------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic compare_err(input logic exp, input logic act);
      if (act !== exp) begin
         stop_on_error($sformatf("FAIL cfg_err expected %h actual %h", exp, act));
      end
   endtask

   task automatic compare_match(input eth_cfg_pkg::match_t exp,
                                input eth_cfg_pkg::match_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("FAIL match expected %h actual %h", exp, act));
      end
   endtask

   // Strobe timing checker in the DUT
   always @(negedge cfg_clk) begin
      if (eth_cfg_top_inst.eth_cfg_assert_inst.fail_cnt != 0) begin
         stop_on_error("A bound assertion on the strobe timing failed");
      end
   end

   // Nonzero random port
   function automatic logic [15:0] rand_port();
      logic [15:0] p;
      p = $random(seed);
      if (p == 16'h0000) begin
         p = 16'h0001;
      end
      return p;
   endfunction

   // Verdict by the match rules, against the model
   function automatic eth_cfg_pkg::match_t predict(input logic [47:0] mac,
                                                   input logic [31:0] ip,
                                                   input logic [15:0] port);
      eth_cfg_pkg::match_t r;
      r        = '0;
      r.mac_ok = (mac == model_mac) || (mac == 48'hffff_ffff_ffff);
      r.ip_ok  = (ip == model_ip);
      if (r.mac_ok && r.ip_ok && port != 16'h0000) begin
         // Lowest slot first
         for (int i = 0; i < `ETH_UDP_SLOTS; i++) begin
            if (!r.hit && model_ports[i] == port) begin
               r.hit  = 1'b1;
               r.slot = `ETH_SLOT_W'(i);
            end
         end
      end
      return r;
   endfunction

   // ------------------------------------------------------------------------
   // Drivers
   // ------------------------------------------------------------------------
   // Raw 5-bit host write, model updated from the address map
   task automatic write_raw(input logic [4:0] addr, input logic [7:0] data);
      logic exp_err;
      int   idx;
      int   slot;
      exp_err = 1'b0;
      idx     = addr[3:0];
      slot    = addr[3:1];
      if (!addr[4]) begin
         if (idx < 6) begin
            model_mac[8*(5-idx) +: 8] = data;
         end else if (idx < 10) begin
            model_ip[8*(9-idx) +: 8] = data;
         end else begin
            exp_err = 1'b1;
         end
      end else if (!addr[0]) begin
         model_ports[slot][15:8] = data;
      end else begin
         model_ports[slot][7:0] = data;
      end
      @(negedge cfg_clk);
      cfg_valid = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge cfg_clk);
      cfg_valid = 1'b0;
      compare_err(exp_err, cfg_err);
   endtask

   // High byte first
   task automatic write_port(input logic [2:0] slot, input logic [15:0] port);
      write_raw({1'b1, slot, 1'b0}, port[15:8]);
      write_raw({1'b1, slot, 1'b1}, port[7:0]);
   endtask

   // One header per call, stays strobed until drain
   task automatic send_hdr(input logic [47:0] mac, input logic [31:0] ip,
                           input logic [15:0] port);
      @(negedge cfg_clk);
      hdr_stb      = 1'b1;
      hdr.dst_mac  = mac;
      hdr.dst_ip   = ip;
      hdr.dst_port = port;
      if (cfg_enable_rx) begin
         due_q.push_back(cyc + 2);
         exp_q.push_back(predict(mac, ip, port));
      end
   endtask

   // Wait out every verdict, then a few idle cycles for strays
   task automatic drain();
      @(negedge cfg_clk);
      hdr_stb = 1'b0;
      while (due_q.size() != 0) begin
         @(negedge cfg_clk);
      end
      repeat (3) @(negedge cfg_clk);
   endtask

   // Verdict checker, strobes matched to the expected queue
   initial begin
      @(posedge rst_n);
      forever begin
         @(negedge cfg_clk);
         if (match_stb) begin
            if (due_q.size() == 0) begin
               stop_on_error("Unexpected match_stb with no header in flight");
            end else if (due_q[0] != cyc) begin
               stop_on_error($sformatf("match_stb in cycle %0d, expected in cycle %0d",
                                       cyc, due_q[0]));
            end else begin
               compare_match(exp_q[0], match);
               void'(due_q.pop_front());
               void'(exp_q.pop_front());
            end
         end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
            stop_on_error("Missing match_stb for an accepted header");
         end
      end
   end

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------
   // Defaults, all slots closed
   task automatic test_defaults();
      send_hdr(`ETH_DEFAULT_MAC, `ETH_DEFAULT_IP, rand_port());
      send_hdr(48'hffff_ffff_ffff, `ETH_DEFAULT_IP, rand_port());
      send_hdr(`ETH_DEFAULT_MAC, `ETH_DEFAULT_IP ^ 32'h1, rand_port());
      send_hdr(`ETH_DEFAULT_MAC, `ETH_DEFAULT_IP, 16'h0000);
      drain();
   endtask

   // New MAC then new IP, old values must fail
   task automatic test_station();
      logic [47:0] old_mac;
      logic [47:0] new_mac;
      logic [31:0] old_ip;
      logic [31:0] new_ip;
      old_mac = model_mac;
      old_ip  = model_ip;
      new_mac = {16'h02a5, 32'($random(seed))};
      new_ip  = $random(seed);
      for (int i = 0; i < 6; i++) begin
         write_raw({1'b0, 4'(i)}, new_mac[8*(5-i) +: 8]);
      end
      send_hdr(old_mac, model_ip, rand_port());
      send_hdr(new_mac, model_ip, rand_port());
      drain();
      for (int i = 0; i < 4; i++) begin
         write_raw({1'b0, 4'(6 + i)}, new_ip[8*(3-i) +: 8]);
      end
      send_hdr(new_mac, old_ip, rand_port());
      send_hdr(new_mac, new_ip, rand_port());
      drain();
   endtask

   // Slot 5 duplicates slot 1
   task automatic test_ports();
      port_a = rand_port();
      port_b = rand_port();
      port_c = rand_port();
      write_port(3'd1, port_a);
      write_port(3'd3, port_b);
      write_port(3'd5, port_a);
      write_port(3'd6, port_c);
      send_hdr(model_mac, model_ip, port_a);
      send_hdr(model_mac, model_ip, port_b);
      send_hdr(model_mac, model_ip, port_c);
      send_hdr(model_mac, model_ip, 16'h0000);
      send_hdr(model_mac, model_ip, port_a ^ port_b ^ port_c ^ 16'h8000);
      send_hdr(model_mac, ~model_ip, port_a);
      send_hdr(~model_mac, model_ip, port_b);
      drain();
   endtask

   // Indices 10..15 have no byte behind them
   task automatic test_illegal();
      int idx;
      for (int k = 0; k < 4; k++) begin
         idx = 10 + ($unsigned($random(seed)) % 6);
         write_raw({1'b0, 4'(idx)}, 8'($random(seed)));
      end
      write_raw(5'b0_1111, 8'hff);
      send_hdr(model_mac, model_ip, port_a);
      send_hdr(48'hffff_ffff_ffff, model_ip, port_c);
      drain();
   endtask

   // Back-to-back headers, then some with receive off
   task automatic test_stream();
      send_hdr(model_mac, model_ip, port_c);
      send_hdr(model_mac, model_ip, port_b);
      send_hdr(model_mac, model_ip, 16'h0000);
      send_hdr(48'hffff_ffff_ffff, model_ip, port_a);
      @(negedge cfg_clk);
      hdr_stb       = 1'b0;
      cfg_enable_rx = 1'b0;
      send_hdr(model_mac, model_ip, port_a);
      send_hdr(model_mac, model_ip, port_b);
      drain();
      cfg_enable_rx = 1'b1;
      send_hdr(model_mac, model_ip, port_b);
      drain();
   endtask

   // Watchdog, twice the summed budget
   initial begin
      #(TOTAL_CYC * 2 * CLK_NS);
      stop_on_error("Timeout, the tests did not finish in their cycle budget");
   end

   initial begin
      cfg_valid     = 1'b0;
      cfg_addr      = '0;
      cfg_wdata     = 8'h00;
      cfg_enable_rx = 1'b0;
      hdr_stb       = 1'b0;
      hdr           = '0;
      rst_n         = 1'b0;
      model_mac     = `ETH_DEFAULT_MAC;
      model_ip      = `ETH_DEFAULT_IP;
      for (int i = 0; i < `ETH_UDP_SLOTS; i++) begin
         model_ports[i] = 16'h0000;
      end
      repeat (10) @(posedge cfg_clk);
      @(negedge cfg_clk);
      rst_n = 1'b1;
      compare_err(1'b0, cfg_err);
      cfg_enable_rx = 1'b1;
      test_defaults();
      test_station();
      test_ports();
      test_illegal();
      test_stream();
      if (eth_cfg_top_inst.eth_cfg_assert_inst.fail_cnt == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         stop_on_error("A bound assertion failed during the run");
      end
   end

endmodule

`default_nettype wire
